// ==== rs_pkg.sv ====
//////////////////////////////
// Reservation station sizes and the
// operand word shared by the slots
//////////////////////////////

package rs_pkg;

    // Data path
    localparam int XLEN = 32;

    // Station geometry
    localparam int RS_DEPTH  = 8;
    localparam int SLOT_BITS = 3;

    // Physical register tag, 256 registers
    localparam int PREG_BITS = 8;

    // Reorder buffer index
    localparam int ROB_BITS = 8;

    // Micro-op code handed to the functional unit
    localparam int UOP_BITS = 4;

    // Pending view of an operand word
    typedef struct packed {
        logic [XLEN-PREG_BITS-1:0] pad;
        logic [PREG_BITS-1:0]      tag;
    } rs_pending_t;

    // One operand word per source
    // Read as a tag while the ready bit is low, as a value once it is high
    typedef union packed {
        logic [XLEN-1:0] value;
        rs_pending_t     pending;
    } rs_operand_t;

endpackage

// ==== rs_entry.sv ====
//////////////////////////////
// One reservation station slot
//////////////////////////////

`timescale 1ns/1ps

module rs_entry (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         write_en,
    input  logic                         grant,
    input  logic [rs_pkg::ROB_BITS-1:0]  rob_in,
    input  logic [rs_pkg::UOP_BITS-1:0]  uop_in,
    input  logic [rs_pkg::XLEN-1:0]      pc_in,
    input  logic [rs_pkg::PREG_BITS-1:0] rs1_tag,
    input  logic                         rs1_ready,
    input  logic [rs_pkg::XLEN-1:0]      rs1_value,
    input  logic [rs_pkg::PREG_BITS-1:0] rs2_tag,
    input  logic                         rs2_ready,
    input  logic [rs_pkg::XLEN-1:0]      rs2_value,
    input  logic                         update_valid,
    input  logic [rs_pkg::PREG_BITS-1:0] update_tag,
    input  logic [rs_pkg::XLEN-1:0]      update_value,
    output logic                         busy,
    output logic                         ready,
    output logic [rs_pkg::ROB_BITS-1:0]  rob,
    output logic [rs_pkg::UOP_BITS-1:0]  uop,
    output logic [rs_pkg::XLEN-1:0]      pc,
    output logic [rs_pkg::XLEN-1:0]      src1,
    output logic [rs_pkg::XLEN-1:0]      src2
);

    rs_pkg::rs_operand_t op1_q;
    rs_pkg::rs_operand_t op2_q;
    logic                rdy1_q;
    logic                rdy2_q;
    logic                hit1_new;
    logic                hit2_new;
    logic                wake1;
    logic                wake2;

    // Builds the stored word for a freshly dispatched operand
    function automatic rs_pkg::rs_operand_t load_operand(
        input logic                         present,
        input logic                         hit,
        input logic [rs_pkg::PREG_BITS-1:0] tag,
        input logic [rs_pkg::XLEN-1:0]      value
    );
        rs_pkg::rs_operand_t op;
        if (present) begin
            op.value = value;
        end else if (hit) begin
            op.value = update_value;
        end else begin
            op.pending.pad = '0;
            op.pending.tag = tag;
        end
        return op;
    endfunction

    // Broadcast seen in the write cycle
    assign hit1_new = update_valid && (rs1_tag == update_tag);
    assign hit2_new = update_valid && (rs2_tag == update_tag);

    // Snoop for operands still waiting
    assign wake1 = busy && !rdy1_q && update_valid && (op1_q.pending.tag == update_tag);
    assign wake2 = busy && !rdy2_q && update_valid && (op2_q.pending.tag == update_tag);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            rdy1_q <= 1'b0;
            rdy2_q <= 1'b0;
        end else if (write_en) begin
            busy   <= 1'b1;
            rdy1_q <= rs1_ready | hit1_new;
            rdy2_q <= rs2_ready | hit2_new;
        end else begin
            if (grant)
                busy <= 1'b0;
            if (wake1)
                rdy1_q <= 1'b1;
            if (wake2)
                rdy2_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            rob   <= rob_in;
            uop   <= uop_in;
            pc    <= pc_in;
            op1_q <= load_operand(rs1_ready, hit1_new, rs1_tag, rs1_value);
            op2_q <= load_operand(rs2_ready, hit2_new, rs2_tag, rs2_value);
        end else begin
            if (wake1)
                op1_q.value <= update_value;
            if (wake2)
                op2_q.value <= update_value;
        end
    end

    assign ready = busy && rdy1_q && rdy2_q;
    assign src1  = op1_q.value;
    assign src2  = op2_q.value;

endmodule

// ==== rs_alloc.sv ====
//////////////////////////////
// Free slot allocator and full flag
//////////////////////////////

`timescale 1ns/1ps

module rs_alloc (
    input  logic                        valid_in,
    input  logic [rs_pkg::RS_DEPTH-1:0] busy,
    output logic [rs_pkg::RS_DEPTH-1:0] write_en,
    output logic                        full
);

    logic [rs_pkg::RS_DEPTH-1:0] free_slots;
    logic [rs_pkg::RS_DEPTH-1:0] pick;
    logic                        found;

    assign free_slots = ~busy;

    // Lowest free index wins
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            if (free_slots[i] && !found) begin
                pick[i] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    // Only write when a micro-op is actually offered
    assign write_en = valid_in ? pick : '0;

    // No free slot left
    assign full = &busy;

endmodule

// ==== rs_issue.sv ====
//////////////////////////////
// Issue select and output stage
//////////////////////////////

`timescale 1ns/1ps

module rs_issue (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic [rs_pkg::RS_DEPTH-1:0]                 ready,
    input  logic [rs_pkg::RS_DEPTH*rs_pkg::ROB_BITS-1:0] slot_rob,
    input  logic [rs_pkg::RS_DEPTH*rs_pkg::UOP_BITS-1:0] slot_uop,
    input  logic [rs_pkg::RS_DEPTH*rs_pkg::XLEN-1:0]    slot_pc,
    input  logic [rs_pkg::RS_DEPTH*rs_pkg::XLEN-1:0]    slot_src1,
    input  logic [rs_pkg::RS_DEPTH*rs_pkg::XLEN-1:0]    slot_src2,
    output logic [rs_pkg::RS_DEPTH-1:0]                 grant,
    output logic                                        valid_out,
    output logic [rs_pkg::ROB_BITS-1:0]                 rob_out,
    output logic [rs_pkg::UOP_BITS-1:0]                 uop_out,
    output logic [rs_pkg::XLEN-1:0]                     pc_out,
    output logic [rs_pkg::XLEN-1:0]                     rs1_out,
    output logic [rs_pkg::XLEN-1:0]                     rs2_out
);

    logic [rs_pkg::SLOT_BITS-1:0] sel;
    logic                         any_ready;

    // Lowest ready slot, one-hot grant plus its index
    always_comb begin
        grant     = '0;
        sel       = '0;
        any_ready = 1'b0;
        for (int i = 0; i < rs_pkg::RS_DEPTH; i++) begin
            if (ready[i] && !any_ready) begin
                grant[i]  = 1'b1;
                sel       = i[rs_pkg::SLOT_BITS-1:0];
                any_ready = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_out <= 1'b0;
            rob_out   <= '0;
            uop_out   <= '0;
            pc_out    <= '0;
            rs1_out   <= '0;
            rs2_out   <= '0;
        end else begin
            valid_out <= any_ready;
            // Fields hold their last issue when nothing is ready
            if (any_ready) begin
                rob_out <= slot_rob[sel*rs_pkg::ROB_BITS +: rs_pkg::ROB_BITS];
                uop_out <= slot_uop[sel*rs_pkg::UOP_BITS +: rs_pkg::UOP_BITS];
                pc_out  <= slot_pc[sel*rs_pkg::XLEN +: rs_pkg::XLEN];
                rs1_out <= slot_src1[sel*rs_pkg::XLEN +: rs_pkg::XLEN];
                rs2_out <= slot_src2[sel*rs_pkg::XLEN +: rs_pkg::XLEN];
            end
        end
    end

endmodule

// ==== rs_top.sv ====
//////////////////////////////
// Reservation station top level
//////////////////////////////

`timescale 1ns/1ps

module rs_top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         valid_in,
    input  logic [rs_pkg::ROB_BITS-1:0]  rob_in,
    input  logic [rs_pkg::UOP_BITS-1:0]  uop_in,
    input  logic [rs_pkg::XLEN-1:0]      pc_in,
    input  logic [rs_pkg::PREG_BITS-1:0] rs1_tag,
    input  logic                         rs1_ready,
    input  logic [rs_pkg::XLEN-1:0]      rs1_value,
    input  logic [rs_pkg::PREG_BITS-1:0] rs2_tag,
    input  logic                         rs2_ready,
    input  logic [rs_pkg::XLEN-1:0]      rs2_value,
    output logic                         full,
    input  logic                         update_valid,
    input  logic [rs_pkg::PREG_BITS-1:0] update_tag,
    input  logic [rs_pkg::XLEN-1:0]      update_value,
    output logic                         valid_out,
    output logic [rs_pkg::ROB_BITS-1:0]  rob_out,
    output logic [rs_pkg::UOP_BITS-1:0]  uop_out,
    output logic [rs_pkg::XLEN-1:0]      pc_out,
    output logic [rs_pkg::XLEN-1:0]      rs1_out,
    output logic [rs_pkg::XLEN-1:0]      rs2_out
);

    logic [rs_pkg::RS_DEPTH-1:0]                  busy;
    logic [rs_pkg::RS_DEPTH-1:0]                  ready;
    logic [rs_pkg::RS_DEPTH-1:0]                  write_en;
    logic [rs_pkg::RS_DEPTH-1:0]                  grant;
    logic [rs_pkg::RS_DEPTH*rs_pkg::ROB_BITS-1:0] slot_rob;
    logic [rs_pkg::RS_DEPTH*rs_pkg::UOP_BITS-1:0] slot_uop;
    logic [rs_pkg::RS_DEPTH*rs_pkg::XLEN-1:0]     slot_pc;
    logic [rs_pkg::RS_DEPTH*rs_pkg::XLEN-1:0]     slot_src1;
    logic [rs_pkg::RS_DEPTH*rs_pkg::XLEN-1:0]     slot_src2;

    rs_alloc u_alloc (
        .valid_in (valid_in),
        .busy     (busy),
        .write_en (write_en),
        .full     (full)
    );

    // Every slot sees the dispatch fields and the result bus
    for (genvar i = 0; i < rs_pkg::RS_DEPTH; i++) begin : g_slot
        rs_entry u_entry (
            .clk          (clk),
            .rst          (rst),
            .write_en     (write_en[i]),
            .grant        (grant[i]),
            .rob_in       (rob_in),
            .uop_in       (uop_in),
            .pc_in        (pc_in),
            .rs1_tag      (rs1_tag),
            .rs1_ready    (rs1_ready),
            .rs1_value    (rs1_value),
            .rs2_tag      (rs2_tag),
            .rs2_ready    (rs2_ready),
            .rs2_value    (rs2_value),
            .update_valid (update_valid),
            .update_tag   (update_tag),
            .update_value (update_value),
            .busy         (busy[i]),
            .ready        (ready[i]),
            .rob          (slot_rob[i*rs_pkg::ROB_BITS +: rs_pkg::ROB_BITS]),
            .uop          (slot_uop[i*rs_pkg::UOP_BITS +: rs_pkg::UOP_BITS]),
            .pc           (slot_pc[i*rs_pkg::XLEN +: rs_pkg::XLEN]),
            .src1         (slot_src1[i*rs_pkg::XLEN +: rs_pkg::XLEN]),
            .src2         (slot_src2[i*rs_pkg::XLEN +: rs_pkg::XLEN])
        );
    end

    rs_issue u_issue (
        .clk       (clk),
        .rst       (rst),
        .ready     (ready),
        .slot_rob  (slot_rob),
        .slot_uop  (slot_uop),
        .slot_pc   (slot_pc),
        .slot_src1 (slot_src1),
        .slot_src2 (slot_src2),
        .grant     (grant),
        .valid_out (valid_out),
        .rob_out   (rob_out),
        .uop_out   (uop_out),
        .pc_out    (pc_out),
        .rs1_out   (rs1_out),
        .rs2_out   (rs2_out)
    );

endmodule

// ==== rs_top_assertions.sv ====
//////////////////////////////
// Port checks bound to rs_top
//////////////////////////////

`timescale 1ns/1ps

module rs_top_assertions (
    input logic clk,
    input logic rst,
    input logic valid_in,
    input logic full,
    input logic valid_out
);

    // Source holds off while every slot is busy
    dispatch_respects_full: assert property (
        @(posedge clk) disable iff (rst) !(valid_in && full))
        else $error("dispatch offered while the station is full");

    flags_known: assert property (
        @(posedge clk) disable iff (rst) !$isunknown({valid_out, full}))
        else $error("valid_out or full is unknown");

    // Nothing can issue in reset or on the first edge after it
    quiet_after_reset: assert property (
        @(posedge clk) (rst || $past(rst)) |-> !valid_out)
        else $error("valid_out high during or right after reset");

endmodule

bind rs_top rs_top_assertions u_assertions (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (valid_in),
    .full      (full),
    .valid_out (valid_out)
);

// ==== rs_top_tb.sv ====
//////////////////////////////
// Reservation station testbench
// with a slot-level reference model
//////////////////////////////

`timescale 1ns/1ps

module rs_top_tb;

    localparam int NUM_ATTEMPTS = 400;
    localparam int MAX_CYCLES   = 20 * NUM_ATTEMPTS + 200;
    localparam int DEPTH        = rs_pkg::RS_DEPTH;
    localparam logic [rs_pkg::PREG_BITS-1:0] FILL_TAG = 8'hF0;
    localparam logic [rs_pkg::PREG_BITS-1:0] SAME_TAG = 8'hA5;

    logic                         clk;
    logic                         rst;
    logic                         valid_in;
    logic [rs_pkg::ROB_BITS-1:0]  rob_in;
    logic [rs_pkg::UOP_BITS-1:0]  uop_in;
    logic [rs_pkg::XLEN-1:0]      pc_in;
    logic [rs_pkg::PREG_BITS-1:0] rs1_tag;
    logic                         rs1_ready;
    logic [rs_pkg::XLEN-1:0]      rs1_value;
    logic [rs_pkg::PREG_BITS-1:0] rs2_tag;
    logic                         rs2_ready;
    logic [rs_pkg::XLEN-1:0]      rs2_value;
    logic                         full;
    logic                         update_valid;
    logic [rs_pkg::PREG_BITS-1:0] update_tag;
    logic [rs_pkg::XLEN-1:0]      update_value;
    logic                         valid_out;
    logic [rs_pkg::ROB_BITS-1:0]  rob_out;
    logic [rs_pkg::UOP_BITS-1:0]  uop_out;
    logic [rs_pkg::XLEN-1:0]      pc_out;
    logic [rs_pkg::XLEN-1:0]      rs1_out;
    logic [rs_pkg::XLEN-1:0]      rs2_out;

    // Model state, one entry per slot
    logic                         m_busy [DEPTH];
    logic                         m_rdy1 [DEPTH];
    logic                         m_rdy2 [DEPTH];
    logic [rs_pkg::PREG_BITS-1:0] m_tag1 [DEPTH];
    logic [rs_pkg::PREG_BITS-1:0] m_tag2 [DEPTH];
    logic [rs_pkg::XLEN-1:0]      m_val1 [DEPTH];
    logic [rs_pkg::XLEN-1:0]      m_val2 [DEPTH];
    logic [rs_pkg::XLEN-1:0]      m_pc   [DEPTH];
    logic [rs_pkg::ROB_BITS-1:0]  m_rob  [DEPTH];
    logic [rs_pkg::UOP_BITS-1:0]  m_uop  [DEPTH];

    // Issue expected at the last edge
    logic                         exp_valid;
    logic [rs_pkg::ROB_BITS-1:0]  exp_rob;
    logic [rs_pkg::UOP_BITS-1:0]  exp_uop;
    logic [rs_pkg::XLEN-1:0]      exp_pc;
    logic [rs_pkg::XLEN-1:0]      exp_src1;
    logic [rs_pkg::XLEN-1:0]      exp_src2;

    logic [31:0] lcg_state;
    logic [31:0] r;
    logic [31:0] bcast_value;
    int          cycles     = 0;
    int          checks     = 0;
    int          errors     = 0;
    int          dispatched = 0;
    int          issued     = 0;

    rs_top UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: station did not drain within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int model_count();
        int n;
        n = 0;
        for (int i = 0; i < DEPTH; i++)
            n += int'(m_busy[i]);
        return n;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic drive_idle();
        valid_in     = 1'b0;
        update_valid = 1'b0;
    endtask

    task automatic drive_update(input logic [rs_pkg::PREG_BITS-1:0] tag,
                                input logic [rs_pkg::XLEN-1:0] value);
        update_valid = 1'b1;
        update_tag   = tag;
        update_value = value;
    endtask

    // Field values are random, operand tags and presence come from the caller
    task automatic drive_uop(
        input logic [rs_pkg::ROB_BITS-1:0]  rob,
        input logic [rs_pkg::PREG_BITS-1:0] tag1,
        input logic                         rdy1,
        input logic [rs_pkg::PREG_BITS-1:0] tag2,
        input logic                         rdy2
    );
        logic [31:0] u;
        u = next_rand();
        valid_in  = 1'b1;
        rob_in    = rob;
        uop_in    = u[19:16];
        pc_in     = next_rand();
        rs1_tag   = tag1;
        rs1_ready = rdy1;
        rs1_value = next_rand();
        rs2_tag   = tag2;
        rs2_ready = rdy2;
        rs2_value = next_rand();
    endtask

    // Issue, snoop, then allocate, all from the state before the edge
    task automatic model_edge();
        int g;
        int a;
        g = -1;
        a = -1;
        for (int i = 0; i < DEPTH; i++) begin
            if (g < 0 && m_busy[i] && m_rdy1[i] && m_rdy2[i])
                g = i;
            if (a < 0 && !m_busy[i] && valid_in)
                a = i;
        end
        exp_valid = (g >= 0);
        if (g >= 0) begin
            exp_rob   = m_rob[g];
            exp_uop   = m_uop[g];
            exp_pc    = m_pc[g];
            exp_src1  = m_val1[g];
            exp_src2  = m_val2[g];
            m_busy[g] = 1'b0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            if (update_valid && m_busy[i] && !m_rdy1[i] && m_tag1[i] == update_tag) begin
                m_rdy1[i] = 1'b1;
                m_val1[i] = update_value;
            end
            if (update_valid && m_busy[i] && !m_rdy2[i] && m_tag2[i] == update_tag) begin
                m_rdy2[i] = 1'b1;
                m_val2[i] = update_value;
            end
        end
        if (a >= 0) begin
            m_busy[a] = 1'b1;
            m_rob[a]  = rob_in;
            m_uop[a]  = uop_in;
            m_pc[a]   = pc_in;
            m_tag1[a] = rs1_tag;
            m_rdy1[a] = rs1_ready || (update_valid && rs1_tag == update_tag);
            m_val1[a] = rs1_ready ? rs1_value : update_value;
            m_tag2[a] = rs2_tag;
            m_rdy2[a] = rs2_ready || (update_valid && rs2_tag == update_tag);
            m_val2[a] = rs2_ready ? rs2_value : update_value;
            dispatched++;
        end
    endtask

    task automatic check_outputs();
        compare_field("full", 32'(full), 32'(model_count() == DEPTH));
        compare_field("valid_out", 32'(valid_out), 32'(exp_valid));
        if (valid_out)
            issued++;
        if (valid_out && exp_valid) begin
            compare_field("rob_out", 32'(rob_out), 32'(exp_rob));
            compare_field("uop_out", 32'(uop_out), 32'(exp_uop));
            compare_field("pc_out", pc_out, exp_pc);
            compare_field("rs1_out", rs1_out, exp_src1);
            compare_field("rs2_out", rs2_out, exp_src2);
        end
    endtask

    task automatic cycle();
        @(posedge clk);
        model_edge();
        #1;
        check_outputs();
    endtask

    initial begin
        lcg_state    = 32'd22;
        clk          = 1'b0;
        rst          = 1'b0;
        valid_in     = 1'b0;
        rob_in       = '0;
        uop_in       = '0;
        pc_in        = '0;
        rs1_tag      = '0;
        rs1_ready    = 1'b0;
        rs1_value    = '0;
        rs2_tag      = '0;
        rs2_ready    = 1'b0;
        rs2_value    = '0;
        update_valid = 1'b0;
        update_tag   = '0;
        update_value = '0;
        exp_valid    = 1'b0;
        for (int i = 0; i < DEPTH; i++)
            m_busy[i] = 1'b0;
        #1;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        compare_field("rob_out", 32'(rob_out), 32'd0);
        compare_field("uop_out", 32'(uop_out), 32'd0);
        compare_field("pc_out", pc_out, 32'd0);
        compare_field("rs1_out", rs1_out, 32'd0);
        compare_field("rs2_out", rs2_out, 32'd0);
        repeat (3) cycle();

        // Eight micro-ops waiting on one tag fill the station
        for (int n = 0; n < DEPTH; n++) begin
            drive_uop(8'(n), FILL_TAG, 1'b0, FILL_TAG, 1'b0);
            cycle();
        end
        drive_idle();
        compare_field("full", 32'(full), 32'd1);
        drive_update(FILL_TAG, next_rand());
        cycle();
        drive_idle();
        cycle();
        compare_field("full", 32'(full), 32'd0);
        // Freed slot 0 should win over slots 2 to 7
        drive_uop(8'h80, SAME_TAG, 1'b1, SAME_TAG, 1'b1);
        cycle();
        drive_idle();
        while (model_count() > 0)
            cycle();

        // Dispatch and matching broadcast on the same edge
        bcast_value = next_rand();
        drive_uop(8'h90, SAME_TAG, 1'b0, SAME_TAG, 1'b0);
        drive_update(SAME_TAG, bcast_value);
        cycle();
        drive_idle();
        cycle();
        compare_field("valid_out", 32'(valid_out), 32'd1);
        compare_field("rs1_out", rs1_out, bcast_value);
        compare_field("rs2_out", rs2_out, bcast_value);

        // Random traffic over a pool of 16 tags
        for (int n = 0; n < NUM_ATTEMPTS; n++) begin
            drive_idle();
            r = next_rand();
            if (model_count() < DEPTH && r[31:30] != 2'b00)
                drive_uop(8'(n), {4'h2, r[27:24]}, r[16], {4'h2, r[23:20]}, r[17]);
            r = next_rand();
            if (r[31])
                drive_update({4'h2, r[27:24]}, next_rand());
            cycle();
        end

        // Wake every pooled tag so the station empties
        for (int t = 0; t < 16; t++) begin
            drive_idle();
            drive_update({4'h2, 4'(t)}, next_rand());
            cycle();
        end
        drive_idle();
        while (model_count() > 0)
            cycle();
        repeat (3) cycle();

        checks++;
        assert (issued == dispatched) else begin
            errors++;
            $display("issued %0d micro-ops but dispatched %0d", issued, dispatched);
        end
        $display("checks %0d, errors %0d, dispatched %0d, issued %0d",
                 checks, errors, dispatched, issued);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== rs_top.f ====
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue.sv
rs_top.sv
rs_top_assertions.sv
rs_top_tb.sv

// ==== Makefile ====
SIM        = verilator
TOP        = rs_top_tb
FILELIST   = rs_top.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A run that stops before printing a result counts as a failure
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '** PASS **' $(LOG); then echo "Simulation gave no result"; exit 1; fi

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
